// ==== verification/gcm_trace.txt ====
# S iv hash_key enc_j0 | B plain keystream last cipher | T tag
# all fields hex, leftmost digit holds block bit 0
S cafebabedeadbeef00000001 40000000000000000000000000000000 11111111222222223333333344444444
B 00112233445566778899aabbccddeeff 00112233445566778899aabbccddeefc 1 00000000000000000000000000000003
T 80911111222222223333333344444404
S 000102030405060708090a0b 40000000000000000000000000000000 aaaaaaaabbbbbbbbccccccccdddddddd
B fedcba98765432100123456789abcdef fedcba98765432100123456789abcdff 0 00000000000000000000000000000010
B 0f0e0d0c0b0a09080706050403020100 0f0e0d0c0b0a09080706050403020101 0 00000000000000000000000000000001
B 5555555555555555aaaaaaaaaaaaaaaa d555555555555555aaaaaaaaaaaaaaaa 1 80000000000000000000000000000000
T b2eaaaaabbbbbbbbccccccccdddddd1c
S ffffffffffffffffffffffff 80000000000000000000000000000000 0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f
B 00000000000000000000000000000000 01000000000000000000000000000000 0 01000000000000000000000000000000
B ffffffffffffffffffffffffffffffff fffdffffffffffffffffffffffffffff 0 00020000000000000000000000000000
B 123456789abcdef0123456789abcdef0 123456789a8cdef0123456789abcdef0 0 00000000003000000000000000000000
B 13579bdf02468ace13579bdf02468ace 13579bdf02468ace13579fdf02468ace 0 00000000000000000000040000000000
B 00000000000000000000000000005000 00000000000000000000000000000000 1 00000000000000000000000000005000
T 0e0d0f0f0f3f0f0f0f0f0b0f0f0f5d8f

// ==== files.f ====
+incdir+src
src/gcm_pkg.sv
src/gf128_mult.sv
src/gcm_gctr.sv
src/gcm_ghash.sv
src/gcm_core.sv
verification/gcm_core_asserts.sv
verification/gcm_core_tb.sv

// ==== Bender.yml ====
package:
  name: gcm_core

sources:
  - include_dirs:
      - src
    files:
      - src/gcm_pkg.sv
      - src/gf128_mult.sv
      - src/gcm_gctr.sv
      - src/gcm_ghash.sv
      - src/gcm_core.sv
  - target: simulation
    include_dirs:
      - src
    files:
      - verification/gcm_core_asserts.sv
      - verification/gcm_core_tb.sv

// ==== verification/gcm_core_tb.sv ====
`timescale 1ns/1ps

`include "gcm_defs.svh"

module gcm_core_tb;

    localparam int TIMEOUT_CYCLES = 50;

    logic            clk;
    logic            i_reset;
    logic            i_start;
    gcm_pkg::iv_t    i_iv;
    gcm_pkg::block_t i_hash_key;
    gcm_pkg::block_t i_enc_j0;
    logic            i_block_valid;
    gcm_pkg::block_t i_plain_block;
    gcm_pkg::block_t i_keystream;
    logic            i_last;
    gcm_pkg::block_t o_counter_block;
    logic            o_cipher_valid;
    gcm_pkg::block_t o_cipher_block;
    logic            o_tag_valid;
    gcm_pkg::block_t o_tag;

    integer       seed;
    int           cycle = 0;
    int           last_cipher_cycle = 0;
    logic [127:0] exp_cipher_q[$];

    gcm_core DUT (.*);

    bind gcm_core gcm_core_asserts u_asserts (
        .clk            (clk),
        .i_reset        (i_reset),
        .i_block_valid  (i_block_valid),
        .o_cipher_valid (o_cipher_valid),
        .o_tag_valid    (o_tag_valid),
        .o_tag          (o_tag)
    );

    initial
    begin
        clk = 1'b0;
    end

    always #10 clk = ~clk;

    // edge count, used to time the tag against the last ciphertext
    always @(posedge clk)
    begin
        cycle <= cycle + 1;
    end

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("*** TEST FAILED ***");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_value(input string name, input logic [127:0] expected,
                               input logic [127:0] actual);
        if (actual !== expected)
        begin
            fail_run($sformatf("Fail: %s expected %h actual %h", name, expected, actual));
        end
    endtask

    task automatic wait_for_tag();
        int waited;
        waited = 0;
        while (o_tag_valid !== 1'b1)
        begin
            if (waited >= TIMEOUT_CYCLES)
            begin
                fail_run("timed out waiting for o_tag_valid after the last block");
            end
            @(negedge clk);
            waited++;
        end
    endtask

    // pops one expected ciphertext per o_cipher_valid
    initial
    begin : cipher_monitor
        int           stall;
        logic [127:0] expected;
        stall = 0;
        forever
        begin
            @(negedge clk);
            if (o_cipher_valid === 1'b1)
            begin
                stall = 0;
                if (exp_cipher_q.size() == 0)
                begin
                    fail_run("o_cipher_valid came with no block outstanding");
                end
                else
                begin
                    expected = exp_cipher_q.pop_front();
                    check_value("ciphertext", expected, o_cipher_block);
                    last_cipher_cycle = cycle;
                end
            end
            else if (exp_cipher_q.size() != 0)
            begin
                stall++;
                if (stall > TIMEOUT_CYCLES)
                begin
                    fail_run("timed out waiting for o_cipher_valid");
                end
            end
        end
    end

    initial
    begin : stimulus
        int            fd;
        int            code;
        int            gap;
        int            messages;
        string         kind;
        string         comment_line;
        gcm_pkg::iv_t  iv;
        gcm_pkg::ctr_t ctr;
        logic [127:0]  h_key;
        logic [127:0]  enc_j0;
        logic [127:0]  plain;
        logic [127:0]  keystream;
        logic [127:0]  cipher;
        logic [127:0]  tag;
        logic          last;

        seed          = 78;
        messages      = 0;
        iv            = '0;
        ctr           = '0;
        i_reset       = 1'b1;
        i_start       = 1'b0;
        i_iv          = '0;
        i_hash_key    = '0;
        i_enc_j0      = '0;
        i_block_valid = 1'b0;
        i_plain_block = '0;
        i_keystream   = '0;
        i_last        = 1'b0;

        fd = $fopen("verification/gcm_trace.txt", "r");
        if (fd == 0)
        begin
            fail_run("could not open verification/gcm_trace.txt");
        end

        repeat (2)
        begin
            @(negedge clk);
            check_value("cipher valid in reset", 0, o_cipher_valid);
            check_value("tag valid in reset", 0, o_tag_valid);
        end
        i_reset = 1'b0;
        @(negedge clk);
        check_value("cipher valid after reset", 0, o_cipher_valid);
        check_value("tag valid after reset", 0, o_tag_valid);

        code = $fscanf(fd, "%s", kind);
        while (code == 1)
        begin
            if (kind.getc(0) == "#")
            begin
                code = $fgets(comment_line, fd);
            end
            else if (kind == "S")
            begin
                code = $fscanf(fd, "%h %h %h", iv, h_key, enc_j0);
                if (code != 3)
                begin
                    fail_run("malformed S line in trace");
                end
                @(negedge clk);
                i_start    = 1'b1;
                i_iv       = iv;
                i_hash_key = h_key;
                i_enc_j0   = enc_j0;
                @(negedge clk);
                // keys must be latched, so take them away again
                i_start    = 1'b0;
                i_iv       = '0;
                i_hash_key = '0;
                i_enc_j0   = '0;
                ctr        = `GCM_FIRST_DATA_CTR;
                check_value("counter block after start", {iv, ctr}, o_counter_block);
            end
            else if (kind == "B")
            begin
                code = $fscanf(fd, "%h %h %h %h", plain, keystream, last, cipher);
                if (code != 4)
                begin
                    fail_run("malformed B line in trace");
                end
                check_value("trace ciphertext", plain ^ keystream, cipher);
                gap = $unsigned($random(seed)) % 4;
                repeat (gap) @(negedge clk);
                check_value("counter block", {iv, ctr}, o_counter_block);
                exp_cipher_q.push_back(cipher);
                i_block_valid = 1'b1;
                i_plain_block = plain;
                i_keystream   = keystream;
                i_last        = last;
                ctr           = ctr + 1'b1;
                @(negedge clk);
                i_block_valid = 1'b0;
                i_last        = 1'b0;
            end
            else if (kind == "T")
            begin
                code = $fscanf(fd, "%h", tag);
                if (code != 1)
                begin
                    fail_run("malformed T line in trace");
                end
                wait_for_tag();
                check_value("tag latency", last_cipher_cycle + 2, cycle);
                check_value("tag", tag, o_tag);
                check_value("ciphertexts outstanding", 0, exp_cipher_q.size());
                @(negedge clk);
                check_value("tag valid pulse width", 0, o_tag_valid);
                messages++;
            end
            else
            begin
                fail_run($sformatf("unknown record %s in trace", kind));
            end
            code = $fscanf(fd, "%s", kind);
        end
        $fclose(fd);

        if (messages > 0)
        begin
            $display("*** TEST PASSED ***");
            $finish;
        end
        else
        begin
            fail_run("trace ended without a checked message");
        end
    end

endmodule

// ==== verification/gcm_core_asserts.sv ====
`timescale 1ns/1ps

module gcm_core_asserts (
    input logic            clk,
    input logic            i_reset,
    input logic            i_block_valid,
    input logic            o_cipher_valid,
    input logic            o_tag_valid,
    input gcm_pkg::block_t o_tag
);

    // tag is a single-cycle pulse
    a_tag_single_pulse: assert property (
        @(posedge clk) disable iff (i_reset)
        o_tag_valid |=> !o_tag_valid
    ) else $error("o_tag_valid high two cycles in a row");

    // one ciphertext per accepted block, one cycle later
    a_cipher_after_block: assert property (
        @(posedge clk) disable iff (i_reset)
        o_cipher_valid |-> $past(i_block_valid)
    ) else $error("o_cipher_valid without i_block_valid the cycle before");

    a_tag_known: assert property (
        @(posedge clk) disable iff (i_reset)
        o_tag_valid |-> !$isunknown(o_tag)
    ) else $error("o_tag has unknown bits while o_tag_valid is high");

endmodule

// ==== src/gcm_core.sv ====
`timescale 1ns/1ps

`include "gcm_defs.svh"

module gcm_core (
    input  logic            clk,
    input  logic            i_reset,
    input  logic            i_start,
    input  gcm_pkg::iv_t    i_iv,
    input  gcm_pkg::block_t i_hash_key,
    input  gcm_pkg::block_t i_enc_j0,
    input  logic            i_block_valid,
    input  gcm_pkg::block_t i_plain_block,
    input  gcm_pkg::block_t i_keystream,
    input  logic            i_last,
    output gcm_pkg::block_t o_counter_block,
    output logic            o_cipher_valid,
    output gcm_pkg::block_t o_cipher_block,
    output logic            o_tag_valid,
    output gcm_pkg::block_t o_tag
);

    // ciphertext stream into the hash stage
    logic            cipher_valid;
    logic            cipher_last;
    gcm_pkg::block_t cipher_block;

    assign o_cipher_valid = cipher_valid;
    assign o_cipher_block = cipher_block;

    gcm_gctr u_gctr (
        .clk             (clk),
        .i_reset         (i_reset),
        .i_start         (i_start),
        .i_iv            (i_iv),
        .i_block_valid   (i_block_valid),
        .i_plain_block   (i_plain_block),
        .i_keystream     (i_keystream),
        .i_last          (i_last),
        .o_counter_block (o_counter_block),
        .o_cipher_valid  (cipher_valid),
        .o_cipher_block  (cipher_block),
        .o_cipher_last   (cipher_last)
    );

    gcm_ghash u_ghash (
        .clk            (clk),
        .i_reset        (i_reset),
        .i_start        (i_start),
        .i_hash_key     (i_hash_key),
        .i_enc_j0       (i_enc_j0),
        .i_cipher_valid (cipher_valid),
        .i_cipher_block (cipher_block),
        .i_cipher_last  (cipher_last),
        .o_tag_valid    (o_tag_valid),
        .o_tag          (o_tag)
    );

endmodule

// ==== src/gcm_ghash.sv ====
`timescale 1ns/1ps

`include "gcm_defs.svh"

module gcm_ghash (
    input  logic            clk,
    input  logic            i_reset,
    input  logic            i_start,
    input  gcm_pkg::block_t i_hash_key,
    input  gcm_pkg::block_t i_enc_j0,
    input  logic            i_cipher_valid,
    input  gcm_pkg::block_t i_cipher_block,
    input  logic            i_cipher_last,
    output logic            o_tag_valid,
    output gcm_pkg::block_t o_tag
);

    gcm_pkg::ghash_state_t state_q;

    gcm_pkg::block_t h_q;
    gcm_pkg::block_t enc_j0_q;
    gcm_pkg::block_t acc_q;
    gcm_pkg::len_t   bit_count_q;

    logic            start_ok;
    logic            absorb;
    gcm_pkg::block_t length_block;
    gcm_pkg::block_t x_sel;
    gcm_pkg::block_t product;

    // a new message only starts once the previous tag is out
    assign start_ok = i_start && (state_q == gcm_pkg::GHASH_IDLE);
    assign absorb   = i_cipher_valid && (state_q == gcm_pkg::GHASH_ABSORB);

    // no AAD, so the upper half is always zero
    assign length_block = {{`GCM_LEN_BITS{1'b0}}, bit_count_q};

    assign x_sel = (state_q == gcm_pkg::GHASH_LENGTH) ? length_block : i_cipher_block;

    // S <- (S ^ X) * H
    gf128_mult u_mult (
        .i_x (acc_q ^ x_sel),
        .i_y (h_q),
        .o_z (product)
    );

    always_ff @(posedge clk)
    begin
        if (i_reset)
        begin
            state_q     <= gcm_pkg::GHASH_IDLE;
            o_tag_valid <= 1'b0;
        end
        else
        begin
            o_tag_valid <= 1'b0;
            case (state_q)
                gcm_pkg::GHASH_IDLE:
                begin
                    if (start_ok)
                    begin
                        state_q <= gcm_pkg::GHASH_ABSORB;
                    end
                end
                gcm_pkg::GHASH_ABSORB:
                begin
                    if (absorb && i_cipher_last)
                    begin
                        state_q <= gcm_pkg::GHASH_LENGTH;
                    end
                end
                gcm_pkg::GHASH_LENGTH:
                begin
                    state_q     <= gcm_pkg::GHASH_IDLE;
                    o_tag_valid <= 1'b1;
                end
                default:
                begin
                    state_q <= gcm_pkg::GHASH_IDLE;
                end
            endcase
        end
    end

    // per-message keys and running hash
    always_ff @(posedge clk)
    begin
        if (start_ok)
        begin
            h_q         <= i_hash_key;
            enc_j0_q    <= i_enc_j0;
            acc_q       <= '0;
            bit_count_q <= '0;
        end
        else if (absorb)
        begin
            acc_q       <= product;
            bit_count_q <= bit_count_q + gcm_pkg::len_t'(`GCM_BLOCK_BITS);
        end
    end

    // final fold with the length block gives the tag
    always_ff @(posedge clk)
    begin
        if (state_q == gcm_pkg::GHASH_LENGTH)
        begin
            o_tag <= product ^ enc_j0_q;
        end
    end

endmodule

// ==== src/gcm_gctr.sv ====
`timescale 1ns/1ps

`include "gcm_defs.svh"

module gcm_gctr (
    input  logic            clk,
    input  logic            i_reset,
    input  logic            i_start,
    input  gcm_pkg::iv_t    i_iv,
    input  logic            i_block_valid,
    input  gcm_pkg::block_t i_plain_block,
    input  gcm_pkg::block_t i_keystream,
    input  logic            i_last,
    output gcm_pkg::block_t o_counter_block,
    output logic            o_cipher_valid,
    output gcm_pkg::block_t o_cipher_block,
    output logic            o_cipher_last
);

    gcm_pkg::iv_t  iv_q;
    gcm_pkg::ctr_t ctr_q;

    // counter block for the cipher outside, IV || counter
    assign o_counter_block = {iv_q, ctr_q};

    always_ff @(posedge clk)
    begin
        if (i_start)
        begin
            iv_q <= i_iv;
        end
    end

    // counter wraps modulo 2^32 by its width
    always_ff @(posedge clk)
    begin
        if (i_reset)
        begin
            ctr_q <= gcm_pkg::ctr_t'(`GCM_FIRST_DATA_CTR);
        end
        else if (i_start)
        begin
            ctr_q <= gcm_pkg::ctr_t'(`GCM_FIRST_DATA_CTR);
        end
        else if (i_block_valid)
        begin
            ctr_q <= ctr_q + gcm_pkg::ctr_t'(1);
        end
    end

    // one cycle from plaintext to ciphertext
    always_ff @(posedge clk)
    begin
        if (i_reset)
        begin
            o_cipher_valid <= 1'b0;
            o_cipher_last  <= 1'b0;
        end
        else
        begin
            o_cipher_valid <= i_block_valid;
            o_cipher_last  <= i_block_valid & i_last;
        end
    end

    always_ff @(posedge clk)
    begin
        if (i_block_valid)
        begin
            o_cipher_block <= i_plain_block ^ i_keystream;
        end
    end

endmodule

// ==== src/gf128_mult.sv ====
`timescale 1ns/1ps

`include "gcm_defs.svh"

module gf128_mult (
    input  gcm_pkg::block_t i_x,
    input  gcm_pkg::block_t i_y,
    output gcm_pkg::block_t o_z
);

    gcm_pkg::block_t z_acc;
    gcm_pkg::block_t v_shift;

    // shift and reduce, walking X from bit 0 (msb) upward
    always_comb
    begin
        z_acc   = '0;
        v_shift = i_y;
        for (int idx = 0; idx < `GCM_BLOCK_BITS; idx++)
        begin
            if (i_x[idx])
            begin
                z_acc = z_acc ^ v_shift;
            end
            // low bit falling out means fold in R
            if (v_shift[`GCM_BLOCK_BITS-1])
            begin
                v_shift = (v_shift >> 1) ^ {`GCM_REDUCE_BYTE, {(`GCM_BLOCK_BITS-8){1'b0}}};
            end
            else
            begin
                v_shift = v_shift >> 1;
            end
        end
        o_z = z_acc;
    end

endmodule

// ==== src/gcm_pkg.sv ====
package gcm_pkg;

    // bit 0 is the most significant bit, as in the GCM spec
    typedef logic [0:127] block_t;
    typedef logic [0:95]  iv_t;
    typedef logic [0:31]  ctr_t;

    // length field, also the running ciphertext bit count
    typedef logic [0:63]  len_t;

    typedef enum logic [1:0] {
        GHASH_IDLE,
        GHASH_ABSORB,
        GHASH_LENGTH
    } ghash_state_t;

endpackage

// ==== src/gcm_defs.svh ====
`ifndef GCM_DEFS_SVH
`define GCM_DEFS_SVH

// one cipher block
`define GCM_BLOCK_BITS 128

// iv, counter part of a counter block
`define GCM_IV_BITS 96
`define GCM_CTR_BITS 32

// each half of the length block
`define GCM_LEN_BITS 64

// leading byte of R = 11100001 || 0^120
`define GCM_REDUCE_BYTE 8'hE1

// J0 takes counter 1, data starts at 2
`define GCM_FIRST_DATA_CTR 2

`endif
